//--- rtl/mtlPkg.sv
// Shared constants for the LCD band controller
//   Pixel color width and band count default
//   Panel timing defaults in pixel clocks and lines
//   APB widths and register map

package mtlPkg;

	// ==========================================================
	// Pixel format
	// ==========================================================
	localparam int COLOR_W       = 24;  // 8 red, 8 green, 8 blue
	localparam int NUM_BANDS_DEF = 4;   // Power of two dividing H_ACTIVE

	// ==========================================================
	// Panel timing (small values for simulation)
	// ==========================================================
	localparam int H_ACTIVE_DEF = 16;   // Visible pixels per line
	localparam int H_FRONT_DEF  = 2;
	localparam int H_SYNC_DEF   = 2;
	localparam int H_BACK_DEF   = 2;

	localparam int V_ACTIVE_DEF = 4;    // Visible lines per frame
	localparam int V_FRONT_DEF  = 1;
	localparam int V_SYNC_DEF   = 1;
	localparam int V_BACK_DEF   = 1;

	// ==========================================================
	// APB register map (byte addresses)
	// ==========================================================
	localparam int ADDR_W = 5;          // Reaches REG_BAND at 16
	localparam int DATA_W = 32;

	localparam logic [ADDR_W-1:0] REG_WEST  = 5'd0;   // Palette color for west swipe
	localparam logic [ADDR_W-1:0] REG_EAST  = 5'd4;   // East swipe
	localparam logic [ADDR_W-1:0] REG_NORTH = 5'd8;   // North swipe
	localparam logic [ADDR_W-1:0] REG_SOUTH = 5'd12;  // South swipe
	localparam logic [ADDR_W-1:0] REG_BAND  = 5'd16;  // Target band index in low bits

endpackage

//--- rtl/bandBus.sv
// Band bus between palette block, band latches and pixel multiplexer
//   feeder modport for the palette block
//   latch modport for each band latch
//   drain modport for the pixel multiplexer

`timescale 1ns/100ps

interface bandBus #(
	parameter int NUM_BANDS = mtlPkg::NUM_BANDS_DEF
) ();
	import mtlPkg::*;

	logic [NUM_BANDS-1:0] loadBand;               // One-hot load strobe per band
	logic [COLOR_W-1:0]   loadColor;              // Color to load into pending
	logic                 frameEnd;               // Swap pending to shown
	logic [COLOR_W-1:0]   shownColor [NUM_BANDS]; // Displayed color per band

	// Palette side drives loads and the swap pulse
	modport feeder (
		output loadBand, loadColor, frameEnd
	);

	// Each latch picks its own bit and element
	modport latch (
		input  loadBand, loadColor, frameEnd,
		output shownColor
	);

	// Multiplexer only reads the shown set
	modport drain (
		input shownColor
	);

endinterface

//--- rtl/paletteRegs.sv
// APB register block for the gesture palette
//   Four palette colors (W, E, N, S) and target band register
//   Gesture pulses become registered one-hot band loads
//   Frame end pulse is passed on to the band latches

`timescale 1ns/100ps

module paletteRegs #(
	parameter int NUM_BANDS = mtlPkg::NUM_BANDS_DEF
) (
	input  logic                      iCLK,
	input  logic                      iRST,
	// APB slave
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [mtlPkg::ADDR_W-1:0] paddr,
	input  logic [mtlPkg::DATA_W-1:0] pwdata,
	output logic [mtlPkg::DATA_W-1:0] prdata,
	// Decoded swipe pulses
	input  logic                      gestW,
	input  logic                      gestE,
	input  logic                      gestN,
	input  logic                      gestS,
	input  logic                      frameEnd,   // From timing generator
	bandBus.feeder                    bus
);
	import mtlPkg::*;

	localparam int BAND_W = (NUM_BANDS > 1) ? $clog2(NUM_BANDS) : 1;

	// ==========================================================
	// Registers
	// ==========================================================
	logic [COLOR_W-1:0]   palette [4];  // Index 0..3 = W, E, N, S
	logic [BAND_W-1:0]    targetBand;
	logic [NUM_BANDS-1:0] loadBandQ;    // One-hot strobe one cycle after gesture
	logic [COLOR_W-1:0]   loadColorQ;
	logic [COLOR_W-1:0]   gestColor;    // Winning gesture color
	logic [DATA_W-1:0]    readData;
	logic                 wrEn;
	logic                 anyGest;

	assign wrEn    = psel & penable & pwrite;          // Access phase of a write
	assign anyGest = gestW | gestE | gestN | gestS;

	// APB writes land on the edge ending the access phase
	always_ff @(posedge iCLK) begin
		if (iRST) begin
			for (int i = 0; i < 4; i++) begin
				palette[i] <= '0;
			end
			targetBand <= '0;
		end else if (wrEn) begin
			case (paddr)
				REG_WEST:  palette[0] <= pwdata[COLOR_W-1:0];
				REG_EAST:  palette[1] <= pwdata[COLOR_W-1:0];
				REG_NORTH: palette[2] <= pwdata[COLOR_W-1:0];
				REG_SOUTH: palette[3] <= pwdata[COLOR_W-1:0];
				REG_BAND:  targetBand <= pwdata[BAND_W-1:0];
				default:   ;                                    // Unmapped writes dropped
			endcase
		end
	end

	// Read mux returns zero for unmapped addresses
	always_comb begin
		case (paddr)
			REG_WEST:  readData = DATA_W'(palette[0]);
			REG_EAST:  readData = DATA_W'(palette[1]);
			REG_NORTH: readData = DATA_W'(palette[2]);
			REG_SOUTH: readData = DATA_W'(palette[3]);
			REG_BAND:  readData = DATA_W'(targetBand);
			default:   readData = '0;
		endcase
	end

	assign prdata = psel ? readData : '0;   // Quiet bus when not selected

	// ==========================================================
	// Gesture to band load
	// ==========================================================
	// Fixed priority W > E > N > S
	always_comb begin
		if (gestW)      gestColor = palette[0];
		else if (gestE) gestColor = palette[1];
		else if (gestN) gestColor = palette[2];
		else            gestColor = palette[3];
	end

	always_ff @(posedge iCLK) begin
		if (iRST) begin
			loadBandQ <= '0;
		end else if (anyGest) begin
			loadBandQ <= NUM_BANDS'(1) << targetBand;   // Strobe the target band only
		end else begin
			loadBandQ <= '0;
		end
	end

	// Payload travels with the strobe
	always_ff @(posedge iCLK) begin
		if (anyGest) loadColorQ <= gestColor;
	end

	assign bus.loadBand  = loadBandQ;
	assign bus.loadColor = loadColorQ;
	assign bus.frameEnd  = frameEnd;      // Swap pulse for all latches

endmodule

//--- rtl/bandLatch.sv
// Double buffered color for one screen band
//   Pending color loaded by its strobe bit
//   Shown color updated only at frame end

`timescale 1ns/100ps

module bandLatch #(
	parameter int BAND = 0              // Bit and element on the bus
) (
	input  logic iCLK,
	input  logic iRST,
	bandBus.latch bus
);
	import mtlPkg::*;

	logic [COLOR_W-1:0] pending;        // Next color for this band
	logic [COLOR_W-1:0] shown;          // Color on screen this frame

	always_ff @(posedge iCLK) begin
		if (iRST) begin
			pending <= '0;
			shown   <= '0;
		end else begin
			if (bus.loadBand[BAND]) begin
				pending <= bus.loadColor;     // Later gesture overwrites earlier one
			end
			// Swap between frames so no tearing mid frame
			if (bus.frameEnd) begin
				shown <= pending;
			end
		end
	end

	assign bus.shownColor[BAND] = shown;

endmodule

//--- rtl/lcdTiming.sv
// LCD timing generator
//   Free running horizontal and vertical counters
//   Active low sync windows and data enable decode
//   Active column index and one cycle frame end pulse

`timescale 1ns/100ps

module lcdTiming #(
	parameter int H_ACTIVE = mtlPkg::H_ACTIVE_DEF,
	parameter int H_FRONT  = mtlPkg::H_FRONT_DEF,
	parameter int H_SYNC   = mtlPkg::H_SYNC_DEF,
	parameter int H_BACK   = mtlPkg::H_BACK_DEF,
	parameter int V_ACTIVE = mtlPkg::V_ACTIVE_DEF,
	parameter int V_FRONT  = mtlPkg::V_FRONT_DEF,
	parameter int V_SYNC   = mtlPkg::V_SYNC_DEF,
	parameter int V_BACK   = mtlPkg::V_BACK_DEF
) (
	input  logic                        iCLK,
	input  logic                        iRST,
	output logic                        hSync,     // Active low
	output logic                        vSync,     // Active low
	output logic                        de,        // Active video
	output logic [$clog2(H_ACTIVE)-1:0] column,    // Pixel column in active area
	output logic                        frameEnd   // Last cycle of frame
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HC_W    = $clog2(H_TOTAL);
	localparam int VC_W    = $clog2(V_TOTAL);
	localparam int COL_W   = $clog2(H_ACTIVE);

	// Window edges, sized to the counters
	localparam logic [HC_W-1:0] H_LAST    = HC_W'(H_TOTAL - 1);
	localparam logic [HC_W-1:0] H_ACT_END = HC_W'(H_ACTIVE);
	localparam logic [HC_W-1:0] H_SYN_BEG = HC_W'(H_ACTIVE + H_FRONT);
	localparam logic [HC_W-1:0] H_SYN_END = HC_W'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [VC_W-1:0] V_LAST    = VC_W'(V_TOTAL - 1);
	localparam logic [VC_W-1:0] V_ACT_END = VC_W'(V_ACTIVE);
	localparam logic [VC_W-1:0] V_SYN_BEG = VC_W'(V_ACTIVE + V_FRONT);
	localparam logic [VC_W-1:0] V_SYN_END = VC_W'(V_ACTIVE + V_FRONT + V_SYNC);

	logic [HC_W-1:0] hCount;   // Pixel within line
	logic [VC_W-1:0] vCount;   // Line within frame
	logic            lineEnd;

	assign lineEnd = (hCount == H_LAST);

	// ==========================================================
	// Counters, reset to start of active video
	// ==========================================================
	always_ff @(posedge iCLK) begin
		if (iRST) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			hCount <= lineEnd ? '0 : hCount + 1'b1;
			if (lineEnd) begin
				vCount <= (vCount == V_LAST) ? '0 : vCount + 1'b1;   // Wrap at frame end
			end
		end
	end

	// ==========================================================
	// Decode
	// ==========================================================
	assign hSync    = ~((hCount >= H_SYN_BEG) && (hCount < H_SYN_END));
	assign vSync    = ~((vCount >= V_SYN_BEG) && (vCount < V_SYN_END));
	assign de       = (hCount < H_ACT_END) && (vCount < V_ACT_END);
	assign column   = hCount[COL_W-1:0];              // Only meaningful with de
	assign frameEnd = lineEnd && (vCount == V_LAST);

endmodule

//--- rtl/pixelMux.sv
// Pixel multiplexer for the band display
//   Column to band lookup
//   Registered RGB output with black outside active video
//   Sync and enable delayed one cycle to stay aligned

`timescale 1ns/100ps

module pixelMux #(
	parameter int NUM_BANDS = mtlPkg::NUM_BANDS_DEF,
	parameter int H_ACTIVE  = mtlPkg::H_ACTIVE_DEF
) (
	input  logic                        iCLK,
	input  logic                        iRST,
	bandBus.drain                       bus,
	input  logic                        hSync,
	input  logic                        vSync,
	input  logic                        de,
	input  logic [$clog2(H_ACTIVE)-1:0] column,
	output logic [7:0]                  mtlR,
	output logic [7:0]                  mtlG,
	output logic [7:0]                  mtlB,
	output logic                        mtlHsd,
	output logic                        mtlVsd,
	output logic                        mtlDe
);
	import mtlPkg::*;

	localparam int COL_W    = $clog2(H_ACTIVE);
	localparam int BAND_W   = (NUM_BANDS > 1) ? $clog2(NUM_BANDS) : 1;
	localparam int BAND_PIX = H_ACTIVE / NUM_BANDS;   // Columns per band

	logic [BAND_W-1:0]  bandIdx;
	logic [COLOR_W-1:0] colorQ;
	logic               hSyncQ, vSyncQ, deQ;

	assign bandIdx = BAND_W'(column / COL_W'(BAND_PIX));   // Constant divide

	// ==========================================================
	// Output stage one cycle after the counters
	// ==========================================================
	always_ff @(posedge iCLK) begin
		if (iRST) begin
			colorQ <= '0;
			hSyncQ <= 1'b1;   // Syncs idle high
			vSyncQ <= 1'b1;
			deQ    <= 1'b0;
		end else begin
			colorQ <= de ? bus.shownColor[bandIdx] : '0;   // Black in blanking
			hSyncQ <= hSync;
			vSyncQ <= vSync;
			deQ    <= de;
		end
	end

	assign mtlR   = colorQ[23:16];
	assign mtlG   = colorQ[15:8];
	assign mtlB   = colorQ[7:0];
	assign mtlHsd = hSyncQ;
	assign mtlVsd = vSyncQ;
	assign mtlDe  = deQ;

endmodule

//--- rtl/mtlController.sv
// Top level of the LCD band controller
//   APB palette block and gesture inputs
//   Timing generator and pixel multiplexer
//   One double buffered latch per band

`timescale 1ns/100ps

module mtlController #(
	parameter int NUM_BANDS = mtlPkg::NUM_BANDS_DEF,
	parameter int H_ACTIVE  = mtlPkg::H_ACTIVE_DEF,
	parameter int H_FRONT   = mtlPkg::H_FRONT_DEF,
	parameter int H_SYNC    = mtlPkg::H_SYNC_DEF,
	parameter int H_BACK    = mtlPkg::H_BACK_DEF,
	parameter int V_ACTIVE  = mtlPkg::V_ACTIVE_DEF,
	parameter int V_FRONT   = mtlPkg::V_FRONT_DEF,
	parameter int V_SYNC    = mtlPkg::V_SYNC_DEF,
	parameter int V_BACK    = mtlPkg::V_BACK_DEF
) (
	input  logic                      iCLK,
	input  logic                      iRST,
	// APB host port
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [mtlPkg::ADDR_W-1:0] paddr,
	input  logic [mtlPkg::DATA_W-1:0] pwdata,
	output logic [mtlPkg::DATA_W-1:0] prdata,
	// Swipes, already decoded
	input  logic                      gestW,
	input  logic                      gestE,
	input  logic                      gestN,
	input  logic                      gestS,
	// Panel side
	output logic [7:0]                mtlR,
	output logic [7:0]                mtlG,
	output logic [7:0]                mtlB,
	output logic                      mtlHsd,   // Active low
	output logic                      mtlVsd,   // Active low
	output logic                      mtlDe
);

	localparam int COL_W = $clog2(H_ACTIVE);

	logic             hSync, vSync, de, frameEnd;
	logic [COL_W-1:0] column;

	bandBus #(.NUM_BANDS(NUM_BANDS)) bus ();

	// ==========================================================
	// Host side
	// ==========================================================
	paletteRegs #(.NUM_BANDS(NUM_BANDS)) i_paletteRegs (
		.iCLK(iCLK), .iRST(iRST),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.gestW(gestW), .gestE(gestE), .gestN(gestN), .gestS(gestS),
		.frameEnd(frameEnd),
		.bus(bus)
	);

	// One latch per band, identical apart from its index
	for (genvar b = 0; b < NUM_BANDS; b++) begin : gBand
		bandLatch #(.BAND(b)) i_bandLatch (
			.iCLK(iCLK), .iRST(iRST),
			.bus(bus)
		);
	end

	// ==========================================================
	// Panel side
	// ==========================================================
	lcdTiming #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) i_lcdTiming (
		.iCLK(iCLK), .iRST(iRST),
		.hSync(hSync), .vSync(vSync), .de(de),
		.column(column), .frameEnd(frameEnd)
	);

	pixelMux #(.NUM_BANDS(NUM_BANDS), .H_ACTIVE(H_ACTIVE)) i_pixelMux (
		.iCLK(iCLK), .iRST(iRST),
		.bus(bus),
		.hSync(hSync), .vSync(vSync), .de(de), .column(column),
		.mtlR(mtlR), .mtlG(mtlG), .mtlB(mtlB),
		.mtlHsd(mtlHsd), .mtlVsd(mtlVsd), .mtlDe(mtlDe)
	);

endmodule

//--- bench/tbModel.svh
// Testbench reference model and helpers
//   Fibonacci LFSR for random stimulus
//   Palette, target band and per-band pending and shown colors
//   Typed compare tasks with error counts

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0]        lfsr = 32'h14f7b1e7;  // Fixed seed
logic [COLOR_W-1:0] mPalette [4];         // W, E, N, S
logic [BAND_W-1:0]  mTarget;
logic [COLOR_W-1:0] mPending [NUM_BANDS];
logic [COLOR_W-1:0] mShown   [NUM_BANDS];
int                 errCount   = 0;
int                 checkCount = 0;
string              curTest    = "";

// Taps 32, 22, 2, 1, one step per bit returned
function automatic logic [31:0] randBits(input int n);
	logic [31:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		r    = {r[30:0], fb};
	end
	return r;
endfunction

task automatic modelReset();
	for (int i = 0; i < 4; i++) mPalette[i] = '0;
	mTarget = '0;
	for (int b = 0; b < NUM_BANDS; b++) begin
		mPending[b] = '0;
		mShown[b]   = '0;
	end
endtask

// Walk from S down to W so the lowest set bit wins
task automatic applyGesture(input logic [3:0] mask);
	for (int i = 3; i >= 0; i--) begin
		if (mask[i]) mPending[mTarget] = mPalette[i];
	end
endtask

task automatic swapModel();
	for (int b = 0; b < NUM_BANDS; b++) mShown[b] = mPending[b];   // Frame boundary
endtask

task automatic checkColor(input string name, input logic [COLOR_W-1:0] expVal, actVal);
	checkCount++;
	if (actVal !== expVal) begin
		errCount++;
		$display("[ERROR] %s: expected %06h, actual %06h", name, expVal, actVal);
	end
endtask

task automatic checkWord(input string name, input logic [DATA_W-1:0] expVal, actVal);
	checkCount++;
	if (actVal !== expVal) begin
		errCount++;
		$display("[ERROR] %s: expected %08h, actual %08h", name, expVal, actVal);
	end
endtask

`endif

//--- bench/tbMtlController.sv
// Testbench for the LCD band controller
//   Clock, reset, APB and gesture stimulus
//   Per-pixel scoreboard against the band model
//   Cycle limit and closing summary

`timescale 1ns/100ps

module tbMtlController;
	import mtlPkg::*;

	localparam int NUM_BANDS   = NUM_BANDS_DEF;
	localparam int BAND_W      = $clog2(NUM_BANDS);
	localparam int BAND_PIX    = H_ACTIVE_DEF / NUM_BANDS;     // Columns per band
	localparam int H_SYN_BEG   = H_ACTIVE_DEF + H_FRONT_DEF;
	localparam int V_SYN_BEG   = V_ACTIVE_DEF + V_FRONT_DEF;
	localparam int H_TOTAL     = H_SYN_BEG + H_SYNC_DEF + H_BACK_DEF;
	localparam int V_TOTAL     = V_SYN_BEG + V_SYNC_DEF + V_BACK_DEF;
	localparam int FRAMES_USED = 60;    // Reset, gestures, priority and 40 random frames
	localparam int MAX_CYCLES  = FRAMES_USED * H_TOTAL * V_TOTAL * 2;

	logic              iCLK, iRST;
	logic              psel, penable, pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata, prdata;
	logic              gestW, gestE, gestN, gestS;
	logic [7:0]        mtlR, mtlG, mtlB;
	logic              mtlHsd, mtlVsd, mtlDe;

	`include "tbModel.svh"

	// Position of the output stream, one cycle behind the counters
	logic tracking = 1'b0;
	logic inFrame  = 1'b0;              // Active pixel seen in this frame
	logic prevDe   = 1'b0;
	logic prevVsd  = 1'b1;
	int   tbH = 0, tbV = 0;
	int   pixCount = 0, lineCount = 0, frameCount = 0;
	int   testCount = 0, cycles = 0;

	mtlController i_mtlController (.*);

	initial begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	// ============================================================
	// Stimulus tasks
	// ============================================================
	task automatic apbXfer(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		@(posedge iCLK);
		psel    <= 1'b1;                // Setup phase
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge iCLK);
		penable <= 1'b1;                // Access phase
		@(negedge iCLK);
		rdata = prdata;
		@(posedge iCLK);                // Write lands on this edge
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic writeColor(input int idx, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] dummy;
		apbXfer(1'b1, ADDR_W'(idx * 4), data, dummy);
		mPalette[idx] = data[COLOR_W-1:0];
	endtask

	task automatic writeBand(input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] dummy;
		apbXfer(1'b1, REG_BAND, data, dummy);
		mTarget = data[BAND_W-1:0];
	endtask

	task automatic sendGesture(input logic [3:0] mask);
		@(posedge iCLK);
		{gestS, gestN, gestE, gestW} <= mask;
		@(posedge iCLK);
		{gestS, gestN, gestE, gestW} <= 4'b0;
		applyGesture(mask);             // Frame end is far off, pending updates now
	endtask

	// Early lines of a frame only
	task automatic waitWindow();
		@(posedge iCLK);
		while (!(inFrame && lineCount < V_ACTIVE_DEF - 1)) @(posedge iCLK);
	endtask

	task automatic waitFrames(input int n);
		int target;
		target = frameCount + n;
		while (frameCount < target) @(posedge iCLK);
	endtask

	task automatic finishTest(input int errsBefore);
		testCount++;
		$display("[DONE] %s: %0d errors", curTest, errCount - errsBefore);
	endtask

	// ============================================================
	// Output scoreboard on the falling edge
	// ============================================================
	task automatic scoreCycle();
		logic [2:0]         expFlags;   // hsync, vsync, de
		logic [COLOR_W-1:0] expColor;
		string              where;
		expFlags[2] = !(tbH >= H_SYN_BEG && tbH < H_SYN_BEG + H_SYNC_DEF);
		expFlags[1] = !(tbV >= V_SYN_BEG && tbV < V_SYN_BEG + V_SYNC_DEF);
		expFlags[0] = (tbH < H_ACTIVE_DEF) && (tbV < V_ACTIVE_DEF);
		expColor    = expFlags[0] ? mShown[tbH / BAND_PIX] : '0;   // Black in blanking
		where       = $sformatf("%s line %0d px %0d", curTest, tbV, tbH);
		checkWord({where, " sync"}, DATA_W'(expFlags), DATA_W'({mtlHsd, mtlVsd, mtlDe}));
		checkColor(where, expColor, {mtlR, mtlG, mtlB});
		if (mtlDe) begin
			pixCount++;
			inFrame = 1'b1;
		end
		if (prevDe && !mtlDe) begin     // End of an active line
			if (pixCount != H_ACTIVE_DEF) begin
				errCount++;
				$display("Line %0d of frame %0d had %0d enabled pixels, not %0d",
					lineCount, frameCount, pixCount, H_ACTIVE_DEF);
			end
			lineCount++;
			pixCount = 0;
		end
		if (prevVsd && !mtlVsd) begin
			if (lineCount != V_ACTIVE_DEF) begin
				errCount++;
				$display("Frame %0d had %0d active lines, not %0d",
					frameCount, lineCount, V_ACTIVE_DEF);
			end
			swapModel();
			lineCount = 0;
			inFrame   = 1'b0;
			frameCount++;
		end
		prevDe  = mtlDe;
		prevVsd = mtlVsd;
		tbH     = (tbH == H_TOTAL - 1) ? 0 : tbH + 1;
		if (tbH == 0) tbV = (tbV == V_TOTAL - 1) ? 0 : tbV + 1;
	endtask

	always @(negedge iCLK) begin
		if (tracking) scoreCycle();
	end

	always @(posedge iCLK) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		int                e0;
		int                stop;
		logic [DATA_W-1:0] rd;
		logic [3:0]        mask;
		iRST    = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		{gestS, gestN, gestE, gestW} = 4'b0;
		modelReset();
		repeat (3) @(posedge iCLK);
		iRST <= 1'b0;
		@(posedge iCLK);
		tracking = 1'b1;                // Next output is column 0 of line 0

		curTest = "resetState";         // Model is all black here
		e0 = errCount;
		waitFrames(1);
		finishTest(e0);

		curTest = "apbReadback";
		e0 = errCount;
		for (int i = 0; i < 4; i++) writeColor(i, randBits(32));
		writeBand(randBits(32));
		for (int i = 0; i < 4; i++) begin
			apbXfer(1'b0, ADDR_W'(i * 4), '0, rd);
			checkWord(curTest, DATA_W'(mPalette[i]), rd);
		end
		apbXfer(1'b0, REG_BAND, '0, rd);
		checkWord(curTest, DATA_W'(mTarget), rd);
		apbXfer(1'b0, ADDR_W'(20), '0, rd);   // Unmapped
		checkWord(curTest, '0, rd);
		finishTest(e0);

		// Issue frame keeps old colors, the next one shows the new band
		curTest = "frameHold";
		e0 = errCount;
		waitWindow();
		writeBand(randBits(32));
		sendGesture(4'(1 << randBits(2)));
		waitFrames(1);
		finishTest(e0);
		curTest = "gestureToBand";
		e0 = errCount;
		waitFrames(1);
		finishTest(e0);

		curTest = "gesturePriority";
		e0 = errCount;
		repeat (4) begin
			waitWindow();
			writeBand(randBits(32));
			mask = 4'(randBits(4)) | 4'(1 << randBits(2));   // Never empty
			sendGesture(mask);
			waitFrames(2);
		end
		finishTest(e0);

		curTest = "randomRun";
		e0 = errCount;
		stop = frameCount + 40;
		while (frameCount < stop) begin
			waitWindow();
			case (randBits(2))
				0:       writeColor(randBits(2), randBits(32));
				1:       writeBand(randBits(32));
				default: sendGesture(4'(randBits(4)));
			endcase
		end
		waitFrames(1);
		finishTest(e0);

		$display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+bench
rtl/mtlPkg.sv
rtl/bandBus.sv
rtl/paletteRegs.sv
rtl/bandLatch.sv
rtl/lcdTiming.sv
rtl/pixelMux.sv
rtl/mtlController.sv
bench/tbMtlController.sv

//--- Makefile
# Verilator build and run for the LCD band controller testbench

VERILATOR ?= verilator
TOP       ?= tbMtlController
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
